// File: vlog.f
+incdir+.
pet_pkg.sv
pet_vid_if.sv
pet_sync_ram.sv
pet_subclock_timing.sv
pet_vram_arbiter.sv
pet_pixel_shifter.sv
pet_core.sv
tb_pet_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pet_core
FLAGS     ?= --binary --timing --assert
BUILD     ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f vlog.f
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf $(BUILD)

// File: tb_pet_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "pet_consts.svh"

module tb_pet_core;

        localparam int CLK_NS       = 4;
        localparam int TEST_PERIODS = 280;      // Char load, bus tests, pixel runs
        localparam int MARGIN       = 40;
        localparam int WATCHDOG_NS  = (TEST_PERIODS + MARGIN) * 32 * CLK_NS;

        logic                    clk;
        logic                    arst_n_i;
        pet_pkg::addr_t          addr_i;
        pet_pkg::byte_t          data_i;
        logic                    we_i;
        pet_pkg::byte_t          data_o;
        pet_pkg::phase_t         phase_i;
        logic                    mode_80col_i;
        logic                    mode_2001_i;
        pet_pkg::ma_t            ma_i;
        pet_pkg::ra_t            ra_i;
        logic                    de_i;
        logic                    blank_i;
        logic                    gfx_i;
        logic                    char_we_i;
        logic [`PET_CHAR_AW-1:0] char_addr_i;
        pet_pkg::byte_t          char_data_i;
        logic                    ce_pixel_o;
        logic                    pix_o;

        // Shadow memories
        pet_pkg::byte_t ram_sh  [2**`PET_RAM_AW];
        pet_pkg::byte_t vram_sh [2**`PET_VRAM_AW];
        pet_pkg::byte_t char_sh [2**`PET_CHAR_AW];

        // Compare state
        int                       rd_arm;       // 1 = address out, 2 = data due
        pet_pkg::addr_t           rd_addr;
        pet_pkg::byte_t           rd_exp;
        logic                     chk_pix;
        logic                     have_cell;    // A loaded cell is being shifted
        logic [3:0]               pix_k;
        pet_pkg::byte_t           cell_code;
        pet_pkg::ra_t             cell_ra;
        logic                     cell_de;
        logic                     cell_gfx;
        logic                     exp_pix;
        logic                     exp_ce;
        logic [`PET_VRAM_AW-1:0]  cell_idx;
        int                       n_err;
        int                       n_chk;

        pet_core i_pet_core (
                .clk          (clk),
                .arst_n_i     (arst_n_i),
                .addr_i       (addr_i),
                .data_i       (data_i),
                .we_i         (we_i),
                .data_o       (data_o),
                .phase_i      (phase_i),
                .mode_80col_i (mode_80col_i),
                .mode_2001_i  (mode_2001_i),
                .ma_i         (ma_i),
                .ra_i         (ra_i),
                .de_i         (de_i),
                .blank_i      (blank_i),
                .gfx_i        (gfx_i),
                .char_we_i    (char_we_i),
                .char_addr_i  (char_addr_i),
                .char_data_i  (char_data_i),
                .ce_pixel_o   (ce_pixel_o),
                .pix_o        (pix_o)
        );

        ////////////////////////////////////////////////////////////////////////////
        // Reference model
        ////////////////////////////////////////////////////////////////////////////

        function automatic logic screen_hit(input pet_pkg::addr_t a, input logic m2001);
                return (a[15:12] == `PET_SCREEN_HI) && (m2001 || !a[11]);      // 2001 mirror
        endfunction

        function automatic logic [`PET_VRAM_AW-1:0] vram_index(input pet_pkg::addr_t a,
                                                               input logic m80);
                if (m80) return a[10:0];
                return {1'b0, a[9:0]};          // 40 columns use 1 KB
        endfunction

        function automatic pet_pkg::byte_t read_ref(input pet_pkg::addr_t a, input logic m80,
                                                    input logic m2001);
                if (!a[15]) return ram_sh[a[14:0]];
                if (screen_hit(a, m2001)) return vram_sh[vram_index(a, m80)];
                return a[15:8];                 // Open bus
        endfunction

        // Pixel k of a cell, MSB first
        function automatic logic pixel_ref(input pet_pkg::byte_t code, input pet_pkg::ra_t ra,
                                           input logic de, input logic gfx, input logic blank,
                                           input logic m2001, input logic [2:0] k);
                pet_pkg::byte_t row;
                logic           inv;
                logic           p;
                row = 8'h00;
                inv = 1'b0;
                if (de && ra < 5'd8) begin
                        row = char_sh[{gfx, code[6:0], ra[2:0]}];
                        inv = code[7];
                end
                p = row[3'd7 - k] ^ inv;
                if (blank && m2001) p = 1'b0;   // 2001 blanking
                return p;
        endfunction

        ////////////////////////////////////////////////////////////////////////////
        // Clock, phase counter, watchdog
        ////////////////////////////////////////////////////////////////////////////

        initial begin
                clk = 1'b0;
                forever #(CLK_NS / 2) clk = ~clk;
        end

        always @(posedge clk) phase_i <= phase_i + 5'd1;       // Free running

        initial begin
                #(WATCHDOG_NS);
                $display("Timeout: the tests did not finish in time");
                $display("Done: errors found");
                $finish;
        end

        ////////////////////////////////////////////////////////////////////////////
        // Compare process
        ////////////////////////////////////////////////////////////////////////////

        always @(negedge clk) begin
                if (rd_arm == 1) begin
                        rd_arm = 2;
                end else if (rd_arm == 2) begin
                        n_chk++;
                        assert (data_o === rd_exp) else begin
                                n_err++;
                                $display("Fail data_o at addr %h: got %h, expected %h",
                                         rd_addr, data_o, rd_exp);
                        end
                        rd_arm = 0;
                end
                if (!chk_pix) begin
                        have_cell = 1'b0;
                end else begin
                        // One clk after each pixel phase
                        exp_ce = mode_80col_i ? !phase_i[0] : (phase_i[1:0] == 2'd2);
                        n_chk++;
                        assert (ce_pixel_o === exp_ce) else begin
                                n_err++;
                                $display("Fail ce_pixel_o at phase %h: got %h, expected %h",
                                         phase_i, ce_pixel_o, exp_ce);
                        end
                end
                if (chk_pix && ce_pixel_o) begin
                        if (have_cell) begin
                                exp_pix = pixel_ref(cell_code, cell_ra, cell_de, cell_gfx,
                                                    blank_i, mode_2001_i, pix_k[2:0]);
                                n_chk++;
                                assert (pix_o === exp_pix) else begin
                                        n_err++;
                                        $display("Fail pix_o code %h pixel %h: got %h, expected %h",
                                                 cell_code, pix_k, pix_o, exp_pix);
                                end
                                pix_k++;
                                if (pix_k == 4'd8) have_cell = 1'b0;
                        end
                        // Capture the cell loaded in this cycle
                        if (phase_i == 5'(`PET_PH_LOAD_END) ||
                            (mode_80col_i && phase_i == 5'(`PET_PH_LOAD_END + `PET_PH_HALF))) begin
                                cell_idx  = mode_80col_i ? {ma_i, phase_i[4]} : {1'b0, ma_i};
                                cell_code = vram_sh[cell_idx];
                                cell_ra   = ra_i;
                                cell_de   = de_i;
                                cell_gfx  = gfx_i;
                                have_cell = 1'b1;
                                pix_k     = 4'd0;
                        end
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Stimulus tasks
        ////////////////////////////////////////////////////////////////////////////

        // Returns at the edge that starts phase p
        task automatic wait_phase(input pet_pkg::phase_t p);
                do @(posedge clk); while (phase_i != p - 5'd1);
        endtask

        task automatic cpu_write(input pet_pkg::addr_t a, input pet_pkg::byte_t d,
                                 input logic full);
                if (full) wait_phase(5'd0);     // Held for a whole period
                else @(posedge clk);
                addr_i <= a;
                data_i <= d;
                we_i   <= 1'b1;
                if (!a[15]) ram_sh[a[14:0]] = d;
                else if (screen_hit(a, mode_2001_i)) vram_sh[vram_index(a, mode_80col_i)] = d;
                repeat (full ? 32 : 1) @(posedge clk);
                we_i   <= 1'b0;
        endtask

        task automatic cpu_read(input pet_pkg::addr_t a, input logic align);
                if (align) wait_phase(5'd0);    // CPU slot
                else @(posedge clk);
                addr_i  <= a;
                we_i    <= 1'b0;
                rd_addr = a;
                rd_exp  = read_ref(a, mode_80col_i, mode_2001_i);
                rd_arm  = 1;
                wait (rd_arm == 0);
        endtask

        // Writes one new code per period to the fetched location
        task automatic run_cells(input int n, input logic m80, input logic m2001,
                                 input logic blank);
                logic [31:0]             r;
                logic [`PET_VRAM_AW-1:0] idx;
                chk_pix = 1'b0;
                r = $urandom();
                @(posedge clk);
                mode_80col_i <= m80;
                mode_2001_i  <= m2001;
                blank_i      <= blank;
                ma_i         <= r[9:0];
                @(posedge clk);
                for (int c = 0; c < n; c++) begin
                        wait_phase(5'd0);
                        r = $urandom();
                        idx = m80 ? {ma_i, c[0]} : {1'b0, ma_i};
                        ra_i   <= {1'b0, r[3:0]};       // Rows 8-15 are gaps
                        de_i   <= (r[6:4] != 3'd0);
                        gfx_i  <= r[7];
                        addr_i <= 16'h8000 | {5'd0, idx};
                        data_i <= r[15:8];
                        we_i   <= 1'b1;
                        vram_sh[idx] = r[15:8];
                        if (c == 2) chk_pix = 1'b1;     // Both 80 column cells written
                end
                wait_phase(5'd0);
                we_i   <= 1'b0;
                addr_i <= '0;
                repeat (40) @(posedge clk);             // Last cell shifts out
                chk_pix = 1'b0;
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Test sequence
        ////////////////////////////////////////////////////////////////////////////

        initial begin
                logic [31:0]             r;
                pet_pkg::addr_t          a;
                pet_pkg::addr_t          wr_q[$];
                logic [`PET_CHAR_AW-1:0] ca;
                r = $urandom(32'h8b6b1ddc);
                arst_n_i = 1'b0;
                addr_i = '0;
                data_i = '0;
                we_i = 1'b0;
                phase_i = '0;
                mode_80col_i = 1'b0;
                mode_2001_i = 1'b0;
                ma_i = '0;
                ra_i = '0;
                de_i = 1'b0;
                blank_i = 1'b0;
                gfx_i = 1'b0;
                char_we_i = 1'b0;
                char_addr_i = '0;
                char_data_i = '0;
                rd_arm = 0;
                chk_pix = 1'b0;
                have_cell = 1'b0;
                pix_k = '0;
                n_err = 0;
                n_chk = 0;
                repeat (3) @(posedge clk);
                arst_n_i <= 1'b1;

                for (int i = 0; i < 2**`PET_CHAR_AW; i++) begin  // Whole char ROM
                        @(posedge clk);
                        r  = $urandom();
                        ca = i[`PET_CHAR_AW-1:0];
                        char_we_i   <= 1'b1;
                        char_addr_i <= ca;
                        char_data_i <= r[7:0];
                        char_sh[ca] = r[7:0];
                end
                @(posedge clk);
                char_we_i <= 1'b0;

                for (int i = 0; i < 64; i++) begin      // Main RAM
                        r = $urandom();
                        a = {1'b0, r[14:0]};
                        wr_q.push_back(a);
                        cpu_write(a, r[22:15], 1'b0);
                end
                foreach (wr_q[j]) cpu_read(wr_q[j], 1'b0);

                for (int i = 0; i < 40; i++) begin      // ROM and I/O ranges
                        r = $urandom();
                        a = r[15:0];
                        a[15:12] = {1'b1, a[14:12]};
                        if (a[15:12] == 4'h8) a[15:12] = 4'hE;
                        cpu_read(a, 1'b0);
                        cpu_read({8'hE8, r[23:16]}, 1'b0);
                end

                for (int m = 0; m < 2; m++) begin       // Screen RAM, both models
                        @(posedge clk);
                        mode_2001_i <= m[0];
                        for (int i = 0; i < 8; i++) begin
                                r = $urandom();
                                a = 16'h8000 | {6'd0, r[9:0]};
                                cpu_write(a, r[17:10], 1'b1);
                                cpu_read(a, 1'b1);
                                cpu_read(a | 16'h0800, 1'b1);   // Mirror or open bus
                        end
                end

                run_cells(40, 1'b0, 1'b0, 1'b0);
                run_cells(40, 1'b1, 1'b0, 1'b0);
                run_cells(20, 1'b0, 1'b1, 1'b1);        // Blanked
                run_cells(20, 1'b0, 1'b0, 1'b1);        // Blank ignored

                $display("Checks: %0d, errors: %0d", n_chk, n_err);
                if (n_err == 0) begin
                        $display("Done: no errors");
                end else begin
                        $display("Done: errors found");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: pet_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "pet_consts.svh"

module pet_core (
        input  wire                     clk,
        input  wire                     arst_n_i,
        // CPU bus
        input  wire pet_pkg::addr_t     addr_i,
        input  wire pet_pkg::byte_t     data_i,
        input  wire                     we_i,
        output pet_pkg::byte_t          data_o,
        // Subclock count and modes
        input  wire pet_pkg::phase_t    phase_i,
        input  wire                     mode_80col_i,
        input  wire                     mode_2001_i,
        // Video timing from outside
        input  wire pet_pkg::ma_t       ma_i,
        input  wire pet_pkg::ra_t       ra_i,
        input  wire                     de_i,
        input  wire                     blank_i,
        input  wire                     gfx_i,
        // Character ROM load
        input  wire                     char_we_i,
        input  wire logic [`PET_CHAR_AW-1:0] char_addr_i,
        input  wire pet_pkg::byte_t     char_data_i,
        // Video out
        output logic                    ce_pixel_o,
        output logic                    pix_o
);

        pet_pkg::byte_t          ram_data;
        pet_pkg::byte_t          vram_data;
        pet_pkg::byte_t          char_data;
        logic                    ram_we;
        logic [`PET_VRAM_AW-1:0] vram_addr;
        logic                    vram_we;
        logic                    vram_hit;
        logic [`PET_CHAR_AW-1:0] char_addr_vid;         // Lookup from the shifter
        logic [`PET_CHAR_AW-1:0] char_addr;

        pet_vid_if vid ();

        ////////////////////////////////////////////////////////////////////////////
        // Memories
        ////////////////////////////////////////////////////////////////////////////

        assign ram_we = we_i && !addr_i[`PET_ADDR_W-1]; // 0000-7FFF

        pet_sync_ram #(.ADDR_W(`PET_RAM_AW)) i_main_ram (
                .clk    (clk),
                .addr_i (addr_i[`PET_RAM_AW-1:0]),
                .data_i (data_i),
                .we_i   (ram_we),
                .data_o (ram_data)
        );

        pet_sync_ram #(.ADDR_W(`PET_VRAM_AW)) i_vram (
                .clk    (clk),
                .addr_i (vram_addr),
                .data_i (data_i),
                .we_i   (vram_we),
                .data_o (vram_data)
        );

        // Loading takes over the lookup port
        assign char_addr = char_we_i ? char_addr_i : char_addr_vid;

        pet_sync_ram #(.ADDR_W(`PET_CHAR_AW)) i_char_rom (
                .clk    (clk),
                .addr_i (char_addr),
                .data_i (char_data_i),
                .we_i   (char_we_i),
                .data_o (char_data)
        );

        ////////////////////////////////////////////////////////////////////////////
        // Video path
        ////////////////////////////////////////////////////////////////////////////

        pet_subclock_timing i_timing (
                .clk          (clk),
                .arst_n_i     (arst_n_i),
                .phase_i      (phase_i),
                .mode_80col_i (mode_80col_i),
                .vid_o        (vid)
        );

        pet_vram_arbiter i_arbiter (
                .addr_i       (addr_i),
                .we_i         (we_i),
                .ma_i         (ma_i),
                .mode_80col_i (mode_80col_i),
                .mode_2001_i  (mode_2001_i),
                .vid_i        (vid),
                .vram_addr_o  (vram_addr),
                .vram_we_o    (vram_we),
                .vram_hit_o   (vram_hit)
        );

        pet_pixel_shifter i_shifter (
                .clk          (clk),
                .arst_n_i     (arst_n_i),
                .vid_i        (vid),
                .vram_data_i  (vram_data),
                .char_data_i  (char_data),
                .ra_i         (ra_i),
                .de_i         (de_i),
                .gfx_i        (gfx_i),
                .blank_i      (blank_i),
                .mode_2001_i  (mode_2001_i),
                .char_addr_o  (char_addr_vid),
                .pix_o        (pix_o)
        );

        assign ce_pixel_o = vid.ce_pixel;

        // Read mux, ROM and I/O ranges float to the high address byte
        always_comb begin
                if (!addr_i[`PET_ADDR_W-1]) begin
                        data_o = ram_data;
                end else if (vram_hit) begin
                        data_o = vram_data;     // 8000-87FF, 8FFF on 2001
                end else begin
                        data_o = addr_i[`PET_ADDR_W-1 -: `PET_DATA_W];  // Open bus
                end
        end

endmodule

`default_nettype wire

// File: pet_pixel_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "pet_consts.svh"

module pet_pixel_shifter (
        input  wire                     clk,
        input  wire                     arst_n_i,
        pet_vid_if.shifter              vid_i,
        input  wire pet_pkg::byte_t     vram_data_i,    // Character code
        input  wire pet_pkg::byte_t     char_data_i,    // Glyph row
        input  wire pet_pkg::ra_t       ra_i,
        input  wire                     de_i,           // Display enable
        input  wire                     gfx_i,          // Graphics vs lower case
        input  wire                     blank_i,
        input  wire                     mode_2001_i,
        output logic [`PET_CHAR_AW-1:0] char_addr_o,
        output logic                    pix_o
);

        pet_pkg::byte_t sr;             // Pixel shift register
        logic           inv;            // Reverse video for this cell
        logic           no_row;         // Rows 8 and up are gaps

        ////////////////////////////////////////////////////////////////////////////
        // Character lookup
        ////////////////////////////////////////////////////////////////////////////

        // Charset half, 7-bit code, 3-bit scan line
        assign char_addr_o = {gfx_i, vram_data_i[6:0], ra_i[2:0]};

        assign no_row = |ra_i[`PET_RA_W-1:3];

        ////////////////////////////////////////////////////////////////////////////
        // Shift register
        ////////////////////////////////////////////////////////////////////////////

        // Screen byte arrives one clk after the fetch, glyph one clk later
        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        sr  <= '0;
                        inv <= 1'b0;
                end else if (vid_i.ce_pixel) begin
                        if (vid_i.load_sr) begin
                                if (de_i && !no_row) begin
                                        sr  <= char_data_i;
                                        inv <= vram_data_i[7];  // Bit 7 inverts
                                end else begin
                                        sr  <= '0;      // Border or gap row
                                        inv <= 1'b0;
                                end
                        end else begin
                                sr <= {sr[`PET_DATA_W-2:0], 1'b0};      // MSB first
                        end
                end
        end

        // Scroll blanking only exists on the 2001
        assign pix_o = (sr[`PET_DATA_W-1] ^ inv) & ~(blank_i & mode_2001_i);

endmodule

`default_nettype wire

// File: pet_vram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "pet_consts.svh"

module pet_vram_arbiter (
        input  wire pet_pkg::addr_t     addr_i,
        input  wire                     we_i,
        input  wire pet_pkg::ma_t       ma_i,           // Matrix address
        input  wire                     mode_80col_i,
        input  wire                     mode_2001_i,
        pet_vid_if.arbiter              vid_i,
        output logic [`PET_VRAM_AW-1:0] vram_addr_o,
        output logic                    vram_we_o,
        output logic                    vram_hit_o      // Also feeds the read mux
);

        logic [`PET_VRAM_AW-1:0] addr_cpu;
        logic [`PET_VRAM_AW-1:0] addr_vid;
        logic                    cpu_sel;

        ////////////////////////////////////////////////////////////////////////////
        // Screen window
        ////////////////////////////////////////////////////////////////////////////

        // 2001 mirrors up to 8FFF, later models stop at 87FF
        assign vram_hit_o = (addr_i[`PET_ADDR_W-1:`PET_ADDR_W-4] == `PET_SCREEN_HI) &&
                            (mode_2001_i || !addr_i[`PET_VRAM_AW]);

        // 40 columns only use the lower KB
        assign addr_cpu = mode_80col_i ? addr_i[`PET_VRAM_AW-1:0]
                                       : {1'b0, addr_i[`PET_VRAM_AW-2:0]};

        // Two cells per CPU cycle in 80 columns
        assign addr_vid = mode_80col_i ? {ma_i, vid_i.fetch_half}
                                       : {1'b0, ma_i};

        ////////////////////////////////////////////////////////////////////////////
        // Address select and write gate
        ////////////////////////////////////////////////////////////////////////////

        // On the 2001 the CPU always wins and the screen shows snow
        assign cpu_sel     = vram_hit_o && (vid_i.cpu_owns || mode_2001_i);
        assign vram_addr_o = cpu_sel ? addr_cpu : addr_vid;

        // No stall as a held write simply lands in the CPU slot
        assign vram_we_o   = we_i && vram_hit_o && vid_i.cpu_owns;

endmodule

`default_nettype wire

// File: pet_subclock_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "pet_consts.svh"

module pet_subclock_timing (
        input  wire                     clk,
        input  wire                     arst_n_i,
        input  wire pet_pkg::phase_t    phase_i,        // External subclock count
        input  wire                     mode_80col_i,
        pet_vid_if.timing               vid_o
);

        pet_pkg::phase_t ph_rel;        // Phase folded onto the first half
        logic            in_fetch;      // Video slot
        logic            in_load;       // Load slot
        logic            pix_slot;      // Phase that yields a pixel

        ////////////////////////////////////////////////////////////////////////////
        // Phase decode
        ////////////////////////////////////////////////////////////////////////////

        // 80 columns repeat the fetch/load pair 16 phases later
        always_comb begin
                if (mode_80col_i && phase_i >= pet_pkg::phase_t'(`PET_PH_HALF)) begin
                        ph_rel = phase_i - pet_pkg::phase_t'(`PET_PH_HALF);
                end else begin
                        ph_rel = phase_i;
                end
        end

        assign in_fetch = (ph_rel >= pet_pkg::phase_t'(`PET_PH_FETCH)) &&
                          (ph_rel <  pet_pkg::phase_t'(`PET_PH_LOAD));
        assign in_load  = (ph_rel >= pet_pkg::phase_t'(`PET_PH_LOAD)) &&
                          (ph_rel <  pet_pkg::phase_t'(`PET_PH_LOAD_END));

        // Every 2 clks in 80 columns, every 4 in 40
        assign pix_slot = mode_80col_i ? phase_i[0] : (phase_i[1:0] == 2'd1);

        ////////////////////////////////////////////////////////////////////////////
        // Registered strobes
        ////////////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        vid_o.ce_pixel   <= 1'b0;
                        vid_o.load_sr    <= 1'b0;
                        vid_o.cpu_owns   <= 1'b1;       // CPU owns screen RAM
                        vid_o.fetch_half <= 1'b0;
                end else begin
                        vid_o.ce_pixel   <= pix_slot;
                        vid_o.load_sr    <= in_load;    // One clk wide
                        vid_o.cpu_owns   <= !in_fetch;  // Low after 3, high after 5
                        vid_o.fetch_half <= phase_i[`PET_PH_W-1];
                end
        end

        // Shifter only loads on a pixel edge, so a lone load would be lost
        a_load_on_pixel: assert property (
                @(posedge clk) disable iff (!arst_n_i)
                vid_o.load_sr |-> vid_o.ce_pixel
        ) else $error("pet_subclock_timing: load_sr without ce_pixel");

endmodule

`default_nettype wire

// File: pet_sync_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "pet_consts.svh"

// Byte RAM, one port, synchronous read
module pet_sync_ram #(
        parameter int ADDR_W = `PET_RAM_AW
) (
        input  wire                     clk,
        input  wire logic [ADDR_W-1:0]  addr_i,
        input  wire pet_pkg::byte_t     data_i,
        input  wire                     we_i,
        output pet_pkg::byte_t          data_o
);

        pet_pkg::byte_t mem [2**ADDR_W]; // Contents survive reset

        always_ff @(posedge clk) begin
                if (we_i) begin
                        mem[addr_i] <= data_i;
                        data_o      <= data_i;  // Write-first
                end else begin
                        data_o      <= mem[addr_i];
                end
        end

        // A write with a floating address would scribble anywhere
        a_wr_addr_known: assert property (
                @(posedge clk) we_i |-> !$isunknown(addr_i)
        ) else $error("pet_sync_ram: write with unknown address");

endmodule

`default_nettype wire

// File: pet_vid_if.sv
`timescale 1ns/1ps
`default_nettype none

// Subclock strobes, one clk behind the phase they decode
interface pet_vid_if;

        logic ce_pixel;         // Pixel enable
        logic load_sr;          // Shift register load, always with ce_pixel
        logic cpu_owns;         // 1 = CPU, 0 = video owns screen RAM
        logic fetch_half;       // Low screen RAM address bit in 80 columns

        // Decoder drives everything
        modport timing (
                output ce_pixel, load_sr, cpu_owns, fetch_half
        );

        // Screen RAM address select
        modport arbiter (
                input cpu_owns, fetch_half
        );

        // Pixel register
        modport shifter (
                input ce_pixel, load_sr
        );

endinterface

`default_nettype wire

// File: pet_pkg.sv
`default_nettype none

`include "pet_consts.svh"

////////////////////////////////////////////////////////////////////////////
// Bus and video types
////////////////////////////////////////////////////////////////////////////

package pet_pkg;

        // CPU side
        typedef logic [`PET_ADDR_W-1:0] addr_t;    // Full CPU address
        typedef logic [`PET_DATA_W-1:0] byte_t;    // Every memory stores bytes

        // Video side, from the external timing source
        typedef logic [`PET_MA_W-1:0]   ma_t;      // Screen cell index
        typedef logic [`PET_RA_W-1:0]   ra_t;      // Scan line in the cell

        // Subclock counter, advanced once per clk from outside
        typedef logic [`PET_PH_W-1:0]   phase_t;

endpackage

`default_nettype wire

// File: pet_consts.svh
`ifndef PET_CONSTS_SVH
`define PET_CONSTS_SVH

// CPU bus
`define PET_ADDR_W      16      // 64 KB address space
`define PET_DATA_W      8

// Memory sizes, as address widths
`define PET_RAM_AW      15      // 32 KB main RAM, 0000-7FFF
`define PET_VRAM_AW     11      // 2 KB screen RAM
`define PET_CHAR_AW     11      // 2 KB character ROM

// Video timing inputs
`define PET_MA_W        10      // Matrix address, 1 KB of cells
`define PET_RA_W        5       // Row address within a character line

// Subclock phases, 32 per CPU cycle
`define PET_PH_W        5
`define PET_PH_FETCH    3       // Video takes the screen RAM
`define PET_PH_LOAD     5       // CPU gets it back, shift register load
`define PET_PH_LOAD_END 6
`define PET_PH_HALF     16      // Second fetch in 80 columns

// Memory map
`define PET_SCREEN_HI   4'h8    // Screen block at 8xxx

`endif
